//--- hdl/dmrs_generator.sv
`timescale 1ns/1ns
`default_nettype none

`include "pbch_cfg.svh"

module dmrs_generator (
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  pbch_pkg::n_id_t      n_id_i,
    input  logic                 n_id_valid_i,
    input  pbch_pkg::pilot_idx_t rd_idx_i,
    output pbch_pkg::dmrs_row_t  row_o,
    output logic [1:0]           start_idx_o,
    output logic                 dmrs_ready_o
);

    import pbch_pkg::*;

    localparam int NUM     = `PBCH_NUM_IBAR;
    localparam int LEN     = `PBCH_LFSR_LEN;
    localparam int STORE_N = 2 * `PBCH_DMRS_PAIRS;
    localparam int PAIR_W  = $clog2(`PBCH_DMRS_PAIRS);
    localparam int CNT_W   = $clog2(`PBCH_GOLD_NC);

    // ST_DONE is also the state after reset, with ready still low
    typedef enum logic [1:0] {ST_DONE, ST_LOAD, ST_SKIP, ST_STORE} gen_state_t;

    gen_state_t       state_q;
    logic [CNT_W-1:0] cnt_q;
    logic             ready_q;
    n_id_t            n_id_q;
    logic             lfsr_load;
    logic             x1_bit;
    logic [NUM-1:0]   x2_bit;
    logic [NUM-1:0]   c_bit;
    logic [NUM-1:0]   hi_q;
    dmrs_row_t        row_wr;
    dmrs_row_t        mem_q [`PBCH_DMRS_PAIRS];

    assign lfsr_load = (state_q == ST_LOAD);

    // x1 starts from x1(0) = 1, shared by all candidates
    gold_lfsr #(
        .TAPS(`PBCH_X1_TAPS)
    ) x1_i (
        .clk_i   (clk_i),
        .reset_ni(reset_ni),
        .load_i  (lfsr_load),
        .init_i  (LEN'(1)),
        .bit_o   (x1_bit)
    );

    for (genvar g = 0; g < NUM; g++) begin : g_x2
        localparam int unsigned IBAR_P1 = g + 1;

        logic [LEN-1:0] c_init;

        // c_init = (ibar+1)(N_id/4+1) 2^11 + (ibar+1) 2^6 + N_id mod 4
        assign c_init = LEN'(((IBAR_P1 * (n_id_q[9:2] + 32'd1)) << 11)
                             + (IBAR_P1 << 6) + n_id_q[1:0]);

        gold_lfsr #(
            .TAPS(`PBCH_X2_TAPS)
        ) x2_i (
            .clk_i   (clk_i),
            .reset_ni(reset_ni),
            .load_i  (lfsr_load),
            .init_i  (c_init),
            .bit_o   (x2_bit[g])
        );
    end

    assign c_bit = {NUM{x1_bit}} ^ x2_bit;

    // odd bit completes the pair, write the whole row at once
    always_comb begin
        for (int c = 0; c < NUM; c++) begin
            row_wr[c] = {hi_q[c], c_bit[c]};
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= ST_DONE;
            cnt_q   <= '0;
            ready_q <= 1'b0;
            n_id_q  <= '0;
        end else if (n_id_valid_i) begin
            // a new cell restarts generation from any state
            state_q <= ST_LOAD;
            cnt_q   <= '0;
            ready_q <= 1'b0;
            n_id_q  <= n_id_i;
        end else begin
            case (state_q)
                ST_LOAD: begin
                    state_q <= ST_SKIP;
                    cnt_q   <= '0;
                end
                ST_SKIP: begin
                    if (cnt_q == CNT_W'(`PBCH_GOLD_NC - 1)) begin
                        state_q <= ST_STORE;
                        cnt_q   <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                ST_STORE: begin
                    if (cnt_q == CNT_W'(STORE_N - 1)) begin
                        state_q <= ST_DONE;
                        ready_q <= 1'b1;
                    end
                    cnt_q <= cnt_q + 1'b1;
                end
                default: begin
                    // hold until the next strobe
                    cnt_q <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_STORE) begin
            if (!cnt_q[0]) begin
                hi_q <= c_bit;
            end else begin
                mem_q[cnt_q[PAIR_W:1]] <= row_wr;
            end
        end
    end

    assign row_o        = mem_q[rd_idx_i];
    assign start_idx_o  = n_id_q[1:0];
    assign dmrs_ready_o = ready_q;

endmodule

`default_nettype wire

//--- hdl/gold_lfsr.sv
`timescale 1ns/1ns
`default_nettype none

`include "pbch_cfg.svh"

module gold_lfsr #(
    parameter logic [`PBCH_LFSR_LEN-1:0] TAPS = `PBCH_X1_TAPS
) (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    input  logic                      load_i,
    input  logic [`PBCH_LFSR_LEN-1:0] init_i,
    output logic                      bit_o
);

    // state_q[i] holds x(n+i), bit 0 leaves first
    logic [`PBCH_LFSR_LEN-1:0] state_q;
    logic                      feedback;

    assign feedback = ^(state_q & TAPS);
    assign bit_o    = state_q[0];

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= '0;
        end else if (load_i) begin
            state_q <= init_i;
        end else begin
            state_q <= {feedback, state_q[`PBCH_LFSR_LEN-1:1]};
        end
    end

endmodule

`default_nettype wire

//--- hdl/ibar_peak_search.sv
`timescale 1ns/1ns
`default_nettype none

`include "pbch_cfg.svh"

module ibar_peak_search (
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  pbch_pkg::corr_bank_t corr_bank_i,
    input  logic                 corr_done_i,
    output pbch_pkg::ibar_t      ibar_o,
    output logic                 ibar_valid_o
);

    import pbch_pkg::*;

    // |corr| reaches 128, the sign bit is not needed
    localparam int MAG_W = $bits(corr_t) - 1;

    typedef logic [MAG_W-1:0] mag_t;

    logic  busy_q;
    logic  fin_q;
    ibar_t cand_q;
    ibar_t best_idx_q;
    mag_t  best_mag_q;
    mag_t  mag_dir;
    mag_t  mag_rot;
    mag_t  mag_cand;

    function automatic mag_t abs_corr(corr_t value);
        corr_t pos;
        pos = (value < 0) ? -value : value;
        return pos[MAG_W-1:0];
    endfunction

    assign mag_dir  = abs_corr(corr_bank_i.dir[cand_q]);
    assign mag_rot  = abs_corr(corr_bank_i.rot[cand_q]);
    assign mag_cand = (mag_rot > mag_dir) ? mag_rot : mag_dir;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            busy_q       <= 1'b0;
            fin_q        <= 1'b0;
            cand_q       <= '0;
            ibar_o       <= '0;
            ibar_valid_o <= 1'b0;
        end else begin
            fin_q        <= 1'b0;
            ibar_valid_o <= fin_q;
            if (fin_q) begin
                ibar_o <= best_idx_q;
            end
            if (corr_done_i) begin
                busy_q <= 1'b1;
                cand_q <= '0;
            end else if (busy_q) begin
                cand_q <= cand_q + 1'b1;
                if (cand_q == ibar_t'(`PBCH_NUM_IBAR - 1)) begin
                    busy_q <= 1'b0;
                    fin_q  <= 1'b1;
                end
            end
        end
    end

    // strictly greater, so ties keep the lower index
    always_ff @(posedge clk_i) begin
        if (corr_done_i) begin
            best_mag_q <= '0;
            best_idx_q <= '0;
        end else if (busy_q && (mag_cand > best_mag_q)) begin
            best_mag_q <= mag_cand;
            best_idx_q <= cand_q;
        end
    end

endmodule

`default_nettype wire

//--- hdl/pbch_cfg.svh
`ifndef PBCH_CFG_SVH
`define PBCH_CFG_SVH

// bits per I or Q component
`define PBCH_IQ_DW          16
// subcarriers per PBCH symbol
`define PBCH_FFT_LEN        256
// number of ibar_SSB candidates
`define PBCH_NUM_IBAR       8
// pilot pairs kept per candidate, one symbol needs no more
`define PBCH_DMRS_PAIRS     64
`define PBCH_PILOT_SPACING  4

// Gold sequence, 38.211 section 5.2.1
`define PBCH_GOLD_NC        1600
`define PBCH_LFSR_LEN       31
// x1(n+31) = x1(n+3) + x1(n)
`define PBCH_X1_TAPS        31'h0000_0009
// x2(n+31) = x2(n+3) + x2(n+2) + x2(n+1) + x2(n)
`define PBCH_X2_TAPS        31'h0000_000F

`endif

//--- hdl/pbch_dmrs_detector.sv
`timescale 1ns/1ns
`default_nettype none

module pbch_dmrs_detector (
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  pbch_pkg::iq_sample_t sample_i,
    input  logic                 sample_valid_i,
    input  logic                 sym_start_i,
    input  pbch_pkg::n_id_t      n_id_i,
    input  logic                 n_id_valid_i,
    output logic                 dmrs_ready_o,
    output pbch_pkg::ibar_t      ibar_o,
    output logic                 ibar_valid_o
);

    import pbch_pkg::*;

    dmrs_row_t  dmrs_row;
    pilot_idx_t rd_idx;
    logic [1:0] start_idx;
    corr_bank_t corr_bank;
    logic       corr_done;

    dmrs_generator gen_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .n_id_i      (n_id_i),
        .n_id_valid_i(n_id_valid_i),
        .rd_idx_i    (rd_idx),
        .row_o       (dmrs_row),
        .start_idx_o (start_idx),
        .dmrs_ready_o(dmrs_ready_o)
    );

    pilot_correlator corr_i (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .sample_i      (sample_i),
        .sample_valid_i(sample_valid_i),
        .sym_start_i   (sym_start_i),
        .dmrs_ready_i  (dmrs_ready_o),
        .start_idx_i   (start_idx),
        .row_i         (dmrs_row),
        .rd_idx_o      (rd_idx),
        .corr_bank_o   (corr_bank),
        .corr_done_o   (corr_done)
    );

    ibar_peak_search peak_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .corr_bank_i (corr_bank),
        .corr_done_i (corr_done),
        .ibar_o      (ibar_o),
        .ibar_valid_o(ibar_valid_o)
    );

endmodule

`default_nettype wire

//--- hdl/pbch_pkg.sv
`default_nettype none

`include "pbch_cfg.svh"

package pbch_pkg;

    typedef struct packed {
        logic signed [`PBCH_IQ_DW-1:0] im;
        logic signed [`PBCH_IQ_DW-1:0] re;
    } iq_sample_t;

    typedef logic [9:0] n_id_t;
    typedef logic [$clog2(`PBCH_NUM_IBAR)-1:0] ibar_t;

    // one QPSK pilot, high bit c(2k), low bit c(2k+1)
    typedef logic [1:0] dmrs_pair_t;

    // pair at one pilot index for every candidate
    typedef dmrs_pair_t [`PBCH_NUM_IBAR-1:0] dmrs_row_t;

    typedef logic [$clog2(`PBCH_DMRS_PAIRS)-1:0] pilot_idx_t;

    // +-2 per pilot over 64 pilots gives +-128
    typedef logic signed [$clog2(2 * `PBCH_DMRS_PAIRS)+1:0] corr_t;

    typedef struct packed {
        corr_t [`PBCH_NUM_IBAR-1:0] dir;
        corr_t [`PBCH_NUM_IBAR-1:0] rot;
    } corr_bank_t;

endpackage

`default_nettype wire

//--- hdl/pilot_correlator.sv
`timescale 1ns/1ns
`default_nettype none

`include "pbch_cfg.svh"

module pilot_correlator (
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  pbch_pkg::iq_sample_t sample_i,
    input  logic                 sample_valid_i,
    input  logic                 sym_start_i,
    input  logic                 dmrs_ready_i,
    input  logic [1:0]           start_idx_i,
    input  pbch_pkg::dmrs_row_t  row_i,
    output pbch_pkg::pilot_idx_t rd_idx_o,
    output pbch_pkg::corr_bank_t corr_bank_o,
    output logic                 corr_done_o
);

    import pbch_pkg::*;

    localparam int SC_W = $clog2(`PBCH_FFT_LEN);
    localparam int SP_W = $clog2(`PBCH_PILOT_SPACING);
    localparam int MSB  = `PBCH_IQ_DW - 1;

    typedef enum logic {ST_IDLE, ST_ACTIVE} corr_state_t;

    corr_state_t     state_q;
    logic [SC_W-1:0] sc_q;
    pilot_idx_t      pilot_q;
    corr_bank_t      bank_q;
    corr_bank_t      bank_d;
    logic            done_q;
    logic            first;
    logic            accept;
    logic            is_pilot;
    logic            last;
    dmrs_pair_t      demod;
    dmrs_pair_t      demod_rot;

    // +1 per matching bit, -1 per differing bit
    function automatic corr_t pair_score(dmrs_pair_t ref_pair, dmrs_pair_t rx);
        corr_t score;
        score = '0;
        for (int b = 0; b < 2; b++) begin
            if (ref_pair[b] == rx[b]) begin
                score = score + corr_t'(1);
            end else begin
                score = score - corr_t'(1);
            end
        end
        return score;
    endfunction

    // hard QPSK decision from the sign bits
    assign demod     = {sample_i.re[MSB], sample_i.im[MSB]};
    // same decision after a 90 degree rotation
    assign demod_rot = {~sample_i.im[MSB], sample_i.re[MSB]};

    // sc_q stays 0 while idle, so the marker sample is subcarrier 0
    assign first    = (state_q == ST_IDLE);
    assign accept   = sample_valid_i && dmrs_ready_i && (sym_start_i || !first);
    assign is_pilot = (sc_q[SP_W-1:0] == start_idx_i);
    assign last     = (sc_q == SC_W'(`PBCH_FFT_LEN - 1));

    always_comb begin
        bank_d = first ? '0 : bank_q;
        if (is_pilot) begin
            for (int c = 0; c < `PBCH_NUM_IBAR; c++) begin
                bank_d.dir[c] = bank_d.dir[c] + pair_score(row_i[c], demod);
                bank_d.rot[c] = bank_d.rot[c] + pair_score(row_i[c], demod_rot);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= ST_IDLE;
            sc_q    <= '0;
            pilot_q <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (!first && !dmrs_ready_i) begin
                // pilots are being regenerated, drop this symbol
                state_q <= ST_IDLE;
                sc_q    <= '0;
                pilot_q <= '0;
            end else if (accept) begin
                if (last) begin
                    state_q <= ST_IDLE;
                    sc_q    <= '0;
                    pilot_q <= '0;
                    done_q  <= 1'b1;
                end else begin
                    state_q <= ST_ACTIVE;
                    sc_q    <= sc_q + 1'b1;
                    if (is_pilot) begin
                        pilot_q <= pilot_q + 1'b1;
                    end
                end
            end
        end
    end

    // held after the last subcarrier until the next marker
    always_ff @(posedge clk_i) begin
        if (accept) begin
            bank_q <= bank_d;
        end
    end

    assign rd_idx_o    = pilot_q;
    assign corr_bank_o = bank_q;
    assign corr_done_o = done_q;

endmodule

`default_nettype wire

//--- list.f
+incdir+hdl
hdl/pbch_pkg.sv
hdl/gold_lfsr.sv
hdl/dmrs_generator.sv
hdl/pilot_correlator.sv
hdl/ibar_peak_search.sv
hdl/pbch_dmrs_detector.sv
sim/pbch_assertions.sv
sim/pbch_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the PBCH DMRS detector testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module pbch_tb -o pbch_sim

./obj_dir/pbch_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
    exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

//--- sim/pbch_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module pbch_assertions (
    input logic clk_i,
    input logic reset_ni,
    input logic n_id_valid_i,
    input logic dmrs_ready_o,
    input logic ibar_valid_o
);

    // a detection is reported by a single-cycle strobe
    valid_pulse_a: assert property (@(posedge clk_i) disable iff (!reset_ni)
        ibar_valid_o |=> !ibar_valid_o)
        else $error("ibar_valid_o stayed high for two cycles");

    // no result without pilot sequences
    valid_ready_a: assert property (@(posedge clk_i) disable iff (!reset_ni)
        $rose(ibar_valid_o) |-> dmrs_ready_o)
        else $error("ibar_valid_o rose while dmrs_ready_o was low");

    // new cell id drops the ready level at once
    ready_drop_a: assert property (@(posedge clk_i) disable iff (!reset_ni)
        n_id_valid_i |=> !dmrs_ready_o)
        else $error("dmrs_ready_o still high after an N_id strobe");

endmodule

`default_nettype wire

//--- sim/pbch_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "pbch_cfg.svh"

module pbch_tb;

    import pbch_pkg::*;

    localparam int FFT    = `PBCH_FFT_LEN;
    localparam int NIBAR  = `PBCH_NUM_IBAR;
    localparam int NPAIR  = `PBCH_DMRS_PAIRS;
    localparam int GOLD_N = `PBCH_GOLD_NC + 2 * NPAIR;
    localparam int NUM_CELLS = 4;
    // three symbols per cell, plus the idle case and the new-cell case
    localparam int NUM_TESTS = 3 * NUM_CELLS + 2;
    localparam longint WATCHDOG_NS = longint'(NUM_TESTS) * 2100 * 20 * 2;

    logic       clk_i;
    logic       reset_ni;
    iq_sample_t sample_i;
    logic       sample_valid_i;
    logic       sym_start_i;
    n_id_t      n_id_i;
    logic       n_id_valid_i;
    logic       dmrs_ready_o;
    ibar_t      ibar_o;
    logic       ibar_valid_o;

    int         errors;
    int         checks;
    n_id_t      cell_id;
    ibar_t      exp_ibar;
    dmrs_pair_t gold_pairs [NIBAR][NPAIR];
    iq_sample_t sym_buf [FFT];
    int         corr_dir [NIBAR];
    int         corr_rot [NIBAR];

    pbch_dmrs_detector dut_i (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .sample_i      (sample_i),
        .sample_valid_i(sample_valid_i),
        .sym_start_i   (sym_start_i),
        .n_id_i        (n_id_i),
        .n_id_valid_i  (n_id_valid_i),
        .dmrs_ready_o  (dmrs_ready_o),
        .ibar_o        (ibar_o),
        .ibar_valid_o  (ibar_valid_o)
    );

    bind pbch_dmrs_detector pbch_assertions assert_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .n_id_valid_i(n_id_valid_i),
        .dmrs_ready_o(dmrs_ready_o),
        .ibar_valid_o(ibar_valid_o)
    );

    initial begin
        clk_i = 1'b0;
    end

    always #10 clk_i = ~clk_i;

    task automatic check_ibar(input ibar_t got, input ibar_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED ibar_o: got 0x%0h expected 0x%0h", got, exp);
        end
    endtask

    task automatic check_ready(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED dmrs_ready_o: got 0x%0h expected 0x%0h", got, exp);
        end
    endtask

    // +1 for every agreeing bit, -1 for every differing bit
    function automatic int bit_agreement(input dmrs_pair_t a, input dmrs_pair_t b);
        int sum;
        sum = 0;
        for (int i = 0; i < 2; i++) begin
            sum += (a[i] == b[i]) ? 1 : -1;
        end
        return sum;
    endfunction

    // x1 and x2 recursions of the Gold sequence, pairs taken after the 1600 skipped bits
    task automatic build_gold(input n_id_t nid);
        logic x1 [GOLD_N + 31];
        logic x2 [GOLD_N + 31];
        int   c_init;
        int   n;
        for (int c = 0; c < NIBAR; c++) begin
            c_init = ((c + 1) * (int'(nid) / 4 + 1)) * 2048 + (c + 1) * 64 + int'(nid) % 4;
            for (n = 0; n < 31; n++) begin
                x1[n] = (n == 0);
                x2[n] = c_init[n];
            end
            for (n = 0; n < GOLD_N; n++) begin
                x1[n + 31] = x1[n + 3] ^ x1[n];
                x2[n + 31] = x2[n + 3] ^ x2[n + 2] ^ x2[n + 1] ^ x2[n];
            end
            for (int k = 0; k < NPAIR; k++) begin
                n = `PBCH_GOLD_NC + 2 * k;
                gold_pairs[c][k] = {x1[n] ^ x2[n], x1[n + 1] ^ x2[n + 1]};
            end
        end
        cell_id = nid;
    endtask

    // all 16 correlations of sym_buf and the winner of the peak search
    task automatic compute_expect();
        dmrs_pair_t rx_dir;
        dmrs_pair_t rx_rot;
        int         k;
        int         mag;
        int         best;
        k = int'(cell_id) % 4;
        for (int c = 0; c < NIBAR; c++) begin
            corr_dir[c] = 0;
            corr_rot[c] = 0;
        end
        for (int s = 0; s < FFT; s++) begin
            if ((s - k) % 4 == 0) begin
                rx_dir = {$signed(sym_buf[s].re) < 0, $signed(sym_buf[s].im) < 0};
                rx_rot = {$signed(sym_buf[s].im) >= 0, $signed(sym_buf[s].re) < 0};
                for (int c = 0; c < NIBAR; c++) begin
                    corr_dir[c] += bit_agreement(gold_pairs[c][(s - k) / 4], rx_dir);
                    corr_rot[c] += bit_agreement(gold_pairs[c][(s - k) / 4], rx_rot);
                end
            end
        end
        best = 0;
        exp_ibar = '0;
        for (int c = 0; c < NIBAR; c++) begin
            mag = (corr_dir[c] < 0) ? -corr_dir[c] : corr_dir[c];
            if (corr_rot[c] > mag || -corr_rot[c] > mag) begin
                mag = (corr_rot[c] < 0) ? -corr_rot[c] : corr_rot[c];
            end
            if (mag > best) begin
                best = mag;
                exp_ibar = ibar_t'(c);
            end
        end
    endtask

    // pilots carry the true candidate's pairs, flip_pct of their bits inverted
    task automatic make_symbol(input int true_ibar, input int flip_pct);
        int         re;
        int         im;
        int         k;
        dmrs_pair_t pair;
        k = int'(cell_id) % 4;
        for (int s = 0; s < FFT; s++) begin
            re = 1 + int'($urandom_range(16000));
            im = 1 + int'($urandom_range(16000));
            pair = dmrs_pair_t'($urandom_range(3));
            if ((s - k) % 4 == 0) begin
                pair = gold_pairs[true_ibar][(s - k) / 4];
                if (int'($urandom_range(99)) < flip_pct) begin
                    pair[1] = ~pair[1];
                end
                if (int'($urandom_range(99)) < flip_pct) begin
                    pair[0] = ~pair[0];
                end
            end
            re = pair[1] ? -re : re;
            im = pair[0] ? -im : im;
            sym_buf[s].re = re[`PBCH_IQ_DW-1:0];
            sym_buf[s].im = im[`PBCH_IQ_DW-1:0];
        end
    endtask

    // multiply by j, magnitudes stay below 2^14 so negation is safe
    task automatic rotate_symbol();
        logic signed [`PBCH_IQ_DW-1:0] tmp;
        for (int s = 0; s < FFT; s++) begin
            tmp = sym_buf[s].re;
            sym_buf[s].re = -sym_buf[s].im;
            sym_buf[s].im = tmp;
        end
    endtask

    task automatic send_symbol(input int gap_pct);
        for (int s = 0; s < FFT; s++) begin
            while (int'($urandom_range(99)) < gap_pct) begin
                @(posedge clk_i);
                #2;
                sample_i = iq_sample_t'($urandom());
                sample_valid_i = 1'b0;
                sym_start_i = 1'b0;
            end
            @(posedge clk_i);
            #2;
            sample_i = sym_buf[s];
            sample_valid_i = 1'b1;
            sym_start_i = (s == 0);
        end
        @(posedge clk_i);
        #2;
        sample_valid_i = 1'b0;
        sym_start_i = 1'b0;
    endtask

    task automatic expect_ibar(input string what);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!ibar_valid_o && n < 100) begin
            @(negedge clk_i);
            n++;
        end
        if (ibar_valid_o) begin
            check_ibar(ibar_o, exp_ibar);
        end else begin
            errors++;
            $display("ERROR: no ibar_valid_o pulse after the %s symbol", what);
        end
    endtask

    task automatic set_cell(input n_id_t nid);
        int n;
        @(posedge clk_i);
        #2;
        n_id_i = nid;
        n_id_valid_i = 1'b1;
        @(posedge clk_i);
        #2;
        n_id_valid_i = 1'b0;
        @(negedge clk_i);
        check_ready(dmrs_ready_o, 1'b0);
        build_gold(nid);
        n = 0;
        while (!dmrs_ready_o && n < 2000) begin
            @(negedge clk_i);
            n++;
        end
        if (!dmrs_ready_o) begin
            errors++;
            $display("ERROR: dmrs_ready_o never rose after the N_id strobe");
        end
    endtask

    initial begin
        int    seed_val;
        int    stray;
        n_id_t nid;
        errors = 0;
        checks = 0;
        seed_val = $urandom(88);
        reset_ni = 1'b0;
        sample_i = '0;
        sample_valid_i = 1'b0;
        sym_start_i = 1'b0;
        n_id_i = '0;
        n_id_valid_i = 1'b0;
        repeat (4) @(posedge clk_i);
        #2;
        reset_ni = 1'b1;

        // nothing may be detected before the first cell id
        @(negedge clk_i);
        check_ready(dmrs_ready_o, 1'b0);
        if (ibar_valid_o !== 1'b0) begin
            errors++;
            $display("ERROR: ibar_valid_o is not low after reset");
        end
        build_gold('0);
        make_symbol(0, 0);
        send_symbol(0);
        stray = 0;
        repeat (400) begin
            @(negedge clk_i);
            stray += int'(ibar_valid_o);
        end
        if (stray != 0) begin
            errors++;
            $display("ERROR: ibar_valid_o pulsed for a symbol sent before any N_id");
        end

        for (int t = 0; t < NUM_CELLS; t++) begin
            nid = n_id_t'($urandom_range(1007));
            set_cell(nid);
            make_symbol(int'($urandom_range(NIBAR - 1)), 0);
            compute_expect();
            send_symbol(0);
            expect_ibar("clean");
            rotate_symbol();
            compute_expect();
            send_symbol(0);
            expect_ibar("rotated");
            make_symbol(int'($urandom_range(NIBAR - 1)), 30);
            compute_expect();
            send_symbol(25);
            expect_ibar("noisy");
        end

        // a different cell must restart the pilot sequences
        nid = n_id_t'((int'(cell_id) + 1 + int'($urandom_range(500))) % 1008);
        set_cell(nid);
        make_symbol(int'($urandom_range(NIBAR - 1)), 10);
        compute_expect();
        send_symbol(10);
        expect_ibar("new cell");

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired after %0d ns with %0d errors", WATCHDOG_NS, errors);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire
